//--- Makefile
TOP := tb_snes_pad_router

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timescale 1ns/1ps -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hw/llapi_pad_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module llapi_pad_decoder (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  logic [snes_pad_pkg::LLAPI_BTN_W-1:0]  llapi_buttons,
	input  logic [snes_pad_pkg::LLAPI_TYPE_W-1:0] llapi_type,
	input  logic                                   llapi_en,
	input  logic                                   llapi_select,
	output logic                                   pad_present,
	output logic [snes_pad_pkg::JOY_W-1:0]        pad_joy,
	output logic                                   pad_osd_combo
);

	snes_pad_pkg::llapi_buttons_u btn;

	logic                           any_pressed;
	logic                           pressed_seen;
	logic                           type_valid;
	logic                           is_saturn;
	logic                           present_next;
	logic                           combo_next;
	logic [snes_pad_pkg::JOY_W-1:0] joy_map;

	assign btn = llapi_buttons;

	assign any_pressed = |llapi_buttons;

	// ========================================
	// Presence
	// ========================================

	// Type 0 can still be a real pad, so a press also counts
	assign type_valid = (llapi_type != snes_pad_pkg::TYPE_NONE_LOW) &&
		(llapi_type != snes_pad_pkg::TYPE_NONE_HIGH);

	// Current word counts in the same cycle the flag gets set
	assign present_next = llapi_en && llapi_select &&
		(type_valid || pressed_seen || any_pressed);

	// Sticky until reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed_seen <= 1'b0;
		end else if (any_pressed) begin
			pressed_seen <= 1'b1;
		end
	end

	// ========================================
	// Button mapping
	// ========================================

	assign is_saturn = (llapi_type == snes_pad_pkg::TYPE_SATURN) ||
		(llapi_type == snes_pad_pkg::TYPE_SATURN_ALT);

	always_comb begin
		if (is_saturn) begin
			// Top face C folds into RT next to the R shoulder
			joy_map = {
				btn.saturn.start,
				btn.saturn.btn_z,
				btn.saturn.btn_r | btn.saturn.btn_c,
				btn.saturn.btn_l,
				btn.saturn.face_left,
				btn.saturn.face_up,
				btn.saturn.face_down,
				btn.saturn.face_right,
				btn.saturn.up,
				btn.saturn.down,
				btn.saturn.left,
				btn.saturn.right
			};
		end else begin
			joy_map = {
				btn.generic.start,
				btn.generic.select,
				btn.generic.btn_r,
				btn.generic.btn_l,
				btn.generic.face_left,
				btn.generic.face_up,
				btn.generic.face_down,
				btn.generic.face_right,
				btn.generic.up,
				btn.generic.down,
				btn.generic.left,
				btn.generic.right
			};
		end
	end

	// ========================================
	// Menu combo
	// ========================================

	// Raw bits regardless of enable and presence
	assign combo_next = llapi_buttons[snes_pad_pkg::BTN_DOWN_POS] &&
		llapi_buttons[snes_pad_pkg::BTN_START_POS] &&
		llapi_buttons[snes_pad_pkg::BTN_A_POS];

	// Output stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pad_present   <= 1'b0;
			pad_joy       <= '0;
			pad_osd_combo <= 1'b0;
		end else begin
			pad_present   <= present_next;
			pad_joy       <= joy_map;
			pad_osd_combo <= combo_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/pad_slot_assigner.sv
`timescale 1ns/1ps
`default_nettype none

module pad_slot_assigner (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            pad_present_1,
	input  logic                            pad_present_2,
	input  logic [snes_pad_pkg::JOY_W-1:0] pad_joy_1,
	input  logic [snes_pad_pkg::JOY_W-1:0] pad_joy_2,
	input  logic                            pad_osd_combo_1,
	input  logic                            pad_osd_combo_2,
	input  logic [snes_pad_pkg::JOY_W-1:0] joy_usb_0,
	input  logic [snes_pad_pkg::JOY_W-1:0] joy_usb_1,
	input  logic [snes_pad_pkg::JOY_W-1:0] joy_usb_2,
	input  logic [snes_pad_pkg::JOY_W-1:0] joy_usb_3,
	input  logic [snes_pad_pkg::JOY_W-1:0] joy_usb_4,
	input  logic                            joy_swap,
	output logic [snes_pad_pkg::JOY_W-1:0] joy_0,
	output logic [snes_pad_pkg::JOY_W-1:0] joy_1,
	output logic [snes_pad_pkg::JOY_W-1:0] joy_2,
	output logic [snes_pad_pkg::JOY_W-1:0] joy_3,
	output logic [snes_pad_pkg::JOY_W-1:0] joy_4,
	output logic                            osd_request
);

	logic [snes_pad_pkg::JOY_W-1:0] usb_q [5];
	logic                           swap_q;

	logic [snes_pad_pkg::JOY_W-1:0] slot [5];
	logic [snes_pad_pkg::JOY_W-1:0] slot_0_sw;
	logic [snes_pad_pkg::JOY_W-1:0] slot_1_sw;

	// ========================================
	// Alignment stage
	// ========================================

	// Matches the decoder register so both sides describe the same input set
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			usb_q[0] <= '0;
			usb_q[1] <= '0;
			usb_q[2] <= '0;
			usb_q[3] <= '0;
			usb_q[4] <= '0;
			swap_q   <= 1'b0;
		end else begin
			usb_q[0] <= joy_usb_0;
			usb_q[1] <= joy_usb_1;
			usb_q[2] <= joy_usb_2;
			usb_q[3] <= joy_usb_3;
			usb_q[4] <= joy_usb_4;
			swap_q   <= joy_swap;
		end
	end

	// ========================================
	// Slot assignment
	// ========================================

	// Native pads first, USB pads move down into what is left
	always_comb begin
		if (pad_present_1 && pad_present_2) begin
			slot[0] = pad_joy_1;
			slot[1] = pad_joy_2;
			slot[2] = usb_q[0];
			slot[3] = usb_q[1];
			slot[4] = usb_q[2];
		end else if (pad_present_1 || pad_present_2) begin
			// USB 0 fills whichever native slot is empty
			slot[0] = pad_present_1 ? pad_joy_1 : usb_q[0];
			slot[1] = pad_present_2 ? pad_joy_2 : usb_q[0];
			slot[2] = usb_q[1];
			slot[3] = usb_q[2];
			slot[4] = usb_q[3];
		end else begin
			slot[0] = usb_q[0];
			slot[1] = usb_q[1];
			slot[2] = usb_q[2];
			slot[3] = usb_q[3];
			slot[4] = usb_q[4];
		end
	end

	// Player swap goes on top of the assignment
	assign slot_0_sw = swap_q ? slot[1] : slot[0];
	assign slot_1_sw = swap_q ? slot[0] : slot[1];

	// ========================================
	// Output stage
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_0       <= '0;
			joy_1       <= '0;
			joy_2       <= '0;
			joy_3       <= '0;
			joy_4       <= '0;
			osd_request <= 1'b0;
		end else begin
			joy_0       <= slot_0_sw;
			joy_1       <= slot_1_sw;
			joy_2       <= slot[2];
			joy_3       <= slot[3];
			joy_4       <= slot[4];
			osd_request <= pad_osd_combo_1 || pad_osd_combo_2;
		end
	end

endmodule

`default_nettype wire

//--- hw/snes_pad_pkg.sv
`default_nettype none

package snes_pad_pkg;

	// ========================================
	// Word widths
	// ========================================

	// Console joypad word
	// {start, select, rt, lt, y, x, b, a, up, down, left, right}
	localparam int JOY_W        = 12;
	localparam int LLAPI_BTN_W  = 32;
	localparam int LLAPI_TYPE_W = 8;

	// ========================================
	// Native controller type codes
	// ========================================

	// Both Saturn pad variants report one of these
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_SATURN     = 8'd3;
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_SATURN_ALT = 8'd8;

	// No pad identified, or an Atari-style pad that cannot report its type
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_NONE_LOW  = 8'd0;
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_NONE_HIGH = 8'd255;

	// Native bits of the menu combo (down + start + A)
	localparam int BTN_A_POS     = 0;
	localparam int BTN_START_POS = 5;
	localparam int BTN_DOWN_POS  = 26;

	// ========================================
	// Native button word layouts
	// ========================================

	// Saturn pad, no select button so Z takes its place
	typedef struct packed {
		logic [3:0]  unused_hi;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
		logic [13:0] unused_mid;
		logic        btn_r;
		logic        btn_l;
		logic        btn_c;
		logic        btn_z;
		logic        start;
		logic        unused_4;
		logic        face_up;
		logic        face_left;
		logic        face_right;
		logic        face_down;
	} saturn_view_t;

	// Any other pad, standard HID order minus one
	typedef struct packed {
		logic [3:0]  unused_hi;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
		logic [15:0] unused_mid;
		logic        btn_r;
		logic        btn_l;
		logic        start;
		logic        select;
		logic        face_up;
		logic        face_left;
		logic        face_right;
		logic        face_down;
	} generic_view_t;

	// Same 32-bit word, read one way or the other by type code
	typedef union packed {
		saturn_view_t  saturn;
		generic_view_t generic;
	} llapi_buttons_u;

endpackage

`default_nettype wire

//--- hw/snes_pad_router.sv
`timescale 1ns/1ps
`default_nettype none

module snes_pad_router (
	input  logic                                   clk_sys,
	input  logic                                   reset,

	// Native pad receivers, one per port
	input  logic [snes_pad_pkg::LLAPI_BTN_W-1:0]  llapi_buttons_1,
	input  logic [snes_pad_pkg::LLAPI_BTN_W-1:0]  llapi_buttons_2,
	input  logic [snes_pad_pkg::LLAPI_TYPE_W-1:0] llapi_type_1,
	input  logic [snes_pad_pkg::LLAPI_TYPE_W-1:0] llapi_type_2,
	input  logic                                   llapi_en_1,
	input  logic                                   llapi_en_2,
	input  logic                                   llapi_select,

	// USB joypads
	input  logic [snes_pad_pkg::JOY_W-1:0]        joy_usb_0,
	input  logic [snes_pad_pkg::JOY_W-1:0]        joy_usb_1,
	input  logic [snes_pad_pkg::JOY_W-1:0]        joy_usb_2,
	input  logic [snes_pad_pkg::JOY_W-1:0]        joy_usb_3,
	input  logic [snes_pad_pkg::JOY_W-1:0]        joy_usb_4,
	input  logic                                   joy_swap,

	// Player slots to the console ports
	output logic [snes_pad_pkg::JOY_W-1:0]        joy_0,
	output logic [snes_pad_pkg::JOY_W-1:0]        joy_1,
	output logic [snes_pad_pkg::JOY_W-1:0]        joy_2,
	output logic [snes_pad_pkg::JOY_W-1:0]        joy_3,
	output logic [snes_pad_pkg::JOY_W-1:0]        joy_4,
	output logic                                   osd_request
);

	logic                           pad_present_1;
	logic                           pad_present_2;
	logic [snes_pad_pkg::JOY_W-1:0] pad_joy_1;
	logic [snes_pad_pkg::JOY_W-1:0] pad_joy_2;
	logic                           pad_osd_combo_1;
	logic                           pad_osd_combo_2;

	// ========================================
	// Native pad decoders
	// ========================================

	llapi_pad_decoder pad_decoder_1 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.llapi_buttons (llapi_buttons_1),
		.llapi_type    (llapi_type_1),
		.llapi_en      (llapi_en_1),
		.llapi_select  (llapi_select),
		.pad_present   (pad_present_1),
		.pad_joy       (pad_joy_1),
		.pad_osd_combo (pad_osd_combo_1)
	);

	llapi_pad_decoder pad_decoder_2 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.llapi_buttons (llapi_buttons_2),
		.llapi_type    (llapi_type_2),
		.llapi_en      (llapi_en_2),
		.llapi_select  (llapi_select),
		.pad_present   (pad_present_2),
		.pad_joy       (pad_joy_2),
		.pad_osd_combo (pad_osd_combo_2)
	);

	// ========================================
	// Player slots
	// ========================================

	pad_slot_assigner slot_assigner (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pad_present_1   (pad_present_1),
		.pad_present_2   (pad_present_2),
		.pad_joy_1       (pad_joy_1),
		.pad_joy_2       (pad_joy_2),
		.pad_osd_combo_1 (pad_osd_combo_1),
		.pad_osd_combo_2 (pad_osd_combo_2),
		.joy_usb_0       (joy_usb_0),
		.joy_usb_1       (joy_usb_1),
		.joy_usb_2       (joy_usb_2),
		.joy_usb_3       (joy_usb_3),
		.joy_usb_4       (joy_usb_4),
		.joy_swap        (joy_swap),
		.joy_0           (joy_0),
		.joy_1           (joy_1),
		.joy_2           (joy_2),
		.joy_3           (joy_3),
		.joy_4           (joy_4),
		.osd_request     (osd_request)
	);

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
hw/snes_pad_pkg.sv
hw/llapi_pad_decoder.sv
hw/pad_slot_assigner.sv
hw/snes_pad_router.sv
test/tb_snes_pad_router.sv

//--- test/pad_model.svh
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

// ========================================
// Reference model of the pad router
// ========================================

// Native word to console word {start, select, rt, lt, y, x, b, a, up, down, left, right}
function automatic logic [11:0] map_native(input logic [31:0] buttons, input logic [7:0] type_code);
	logic        saturn;
	logic [11:0] word;
	saturn    = (type_code == 8'd3) || (type_code == 8'd8);
	word[11]  = buttons[5];
	word[10]  = saturn ? buttons[6] : buttons[4];
	word[9]   = saturn ? (buttons[9] | buttons[7]) : buttons[7];
	word[8]   = saturn ? buttons[8] : buttons[6];
	word[7]   = buttons[2];
	word[6]   = buttons[3];
	word[5]   = buttons[0];
	word[4]   = buttons[1];
	word[3:0] = buttons[27:24];
	return word;
endfunction

// Down, start and A together
function automatic logic combo_held(input logic [31:0] buttons);
	return buttons[26] && buttons[5] && buttons[0];
endfunction

// Pressed is the history flag from earlier words since reset
function automatic logic pad_is_present(input logic en, input logic sel,
	input logic [7:0] type_code, input logic pressed, input logic [31:0] buttons);
	logic type_known;
	type_known = (type_code != 8'd0) && (type_code != 8'd255);
	return en && sel && (type_known || pressed || (buttons != 32'd0));
endfunction

// USB words packed as {usb 4, ..., usb 0}, result as {slot 4, ..., slot 0}
function automatic logic [59:0] assign_slots(input logic present_1, input logic present_2,
	input logic [11:0] joy_1, input logic [11:0] joy_2, input logic [59:0] usb,
	input logic swap);
	logic [11:0] slot [5];
	logic [11:0] held;
	if (present_1 && present_2) begin
		slot[0] = joy_1;
		slot[1] = joy_2;
		for (int i = 2; i < 5; i++) begin
			slot[i] = usb[12*(i-2) +: 12];
		end
	end else if (present_1 || present_2) begin
		// USB 0 covers the missing native pad
		slot[0] = present_1 ? joy_1 : usb[11:0];
		slot[1] = present_2 ? joy_2 : usb[11:0];
		for (int i = 2; i < 5; i++) begin
			slot[i] = usb[12*(i-1) +: 12];
		end
	end else begin
		for (int i = 0; i < 5; i++) begin
			slot[i] = usb[12*i +: 12];
		end
	end
	if (swap) begin
		held    = slot[0];
		slot[0] = slot[1];
		slot[1] = held;
	end
	return {slot[4], slot[3], slot[2], slot[1], slot[0]};
endfunction

`endif

//--- test/tb_snes_pad_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snes_pad_router;

	`include "pad_model.svh"

	localparam int CLK_PERIOD  = 20;
	localparam int N_IDLE      = 200;
	localparam int N_BOTH      = 400;
	localparam int N_ONE       = 400;
	localparam int STICKY_IDLE = 20;
	localparam int STICKY_HOLD = 30;
	localparam int N_STICKY    = 2 * STICKY_IDLE + 2 * STICKY_HOLD + 2;
	localparam int N_RANDOM    = 3000;
	localparam int RESET_EVERY = 500;
	// One initial reset plus two in the sticky phase and six in the random run
	localparam int N_RESETS    = 9;
	localparam int TIMEOUT_NS  = (N_IDLE + N_BOTH + N_ONE + N_STICKY + N_RANDOM +
		4 * N_RESETS + 200) * CLK_PERIOD;

	localparam int MODE_IDLE   = 0;
	localparam int MODE_BOTH   = 1;
	localparam int MODE_ONE    = 2;
	localparam int MODE_RANDOM = 3;

	logic        clk_sys;
	logic        reset;
	logic [31:0] llapi_buttons_1;
	logic [31:0] llapi_buttons_2;
	logic [7:0]  llapi_type_1;
	logic [7:0]  llapi_type_2;
	logic        llapi_en_1;
	logic        llapi_en_2;
	logic        llapi_select;
	logic [11:0] joy_usb_0;
	logic [11:0] joy_usb_1;
	logic [11:0] joy_usb_2;
	logic [11:0] joy_usb_3;
	logic [11:0] joy_usb_4;
	logic        joy_swap;
	logic [11:0] joy_0;
	logic [11:0] joy_1;
	logic [11:0] joy_2;
	logic [11:0] joy_3;
	logic [11:0] joy_4;
	logic        osd_request;

	// Next input set and model state
	logic [31:0] nx_buttons_1;
	logic [31:0] nx_buttons_2;
	logic [7:0]  nx_type_1;
	logic [7:0]  nx_type_2;
	logic        nx_en_1;
	logic        nx_en_2;
	logic        nx_select;
	logic        nx_swap;
	logic [59:0] nx_usb;
	logic        pressed_1;
	logic        pressed_2;
	logic [60:0] exp_q [$];

	snes_pad_router DUT (.*);

	// ========================================
	// Clock and watchdog
	// ========================================

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout: the run was still going after %0d ns", TIMEOUT_NS);
	end

	// ========================================
	// Checks
	// ========================================

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "Output mismatch on %s", name);
		end
	endtask

	// Expected word is {osd, slot 4, ..., slot 0}
	task automatic compare_outputs(input logic [60:0] expected);
		check_value("joy_0", 32'(joy_0), 32'(expected[11:0]));
		check_value("joy_1", 32'(joy_1), 32'(expected[23:12]));
		check_value("joy_2", 32'(joy_2), 32'(expected[35:24]));
		check_value("joy_3", 32'(joy_3), 32'(expected[47:36]));
		check_value("joy_4", 32'(joy_4), 32'(expected[59:48]));
		check_value("osd_request", 32'(osd_request), 32'(expected[60]));
	endtask

	// ========================================
	// Stimulus
	// ========================================

	task automatic drive_zero_inputs();
		llapi_buttons_1 <= '0;
		llapi_buttons_2 <= '0;
		llapi_type_1    <= '0;
		llapi_type_2    <= '0;
		llapi_en_1      <= 1'b0;
		llapi_en_2      <= 1'b0;
		llapi_select    <= 1'b0;
		{joy_usb_4, joy_usb_3, joy_usb_2, joy_usb_1, joy_usb_0} <= '0;
		joy_swap        <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		drive_zero_inputs();
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		compare_outputs('0);
		exp_q.delete();
		pressed_1 = 1'b0;
		pressed_2 = 1'b0;
	endtask

	function automatic logic [31:0] draw_buttons();
		logic [31:0] word;
		word = $urandom();
		// Menu combo often enough to show up
		if ($urandom_range(3, 0) == 0) begin
			word = word | 32'h0400_0021;
		end
		return word;
	endfunction

	// Boundary codes weighted heavily
	function automatic logic [7:0] draw_type(input logic valid_only);
		logic [31:0] pick;
		pick = $urandom_range(5, valid_only ? 2 : 0);
		case (pick)
			0: return 8'd0;
			1: return 8'd255;
			2: return 8'd3;
			3: return 8'd8;
			default: return 8'($urandom_range(254, 1));
		endcase
	endfunction

	task automatic draw_stimulus(input int mode);
		logic [31:0] r;
		logic        port_2_only;
		for (int i = 0; i < 5; i++) begin
			r = $urandom();
			nx_usb[12*i +: 12] = r[11:0];
		end
		nx_buttons_1 = draw_buttons();
		nx_buttons_2 = draw_buttons();
		nx_swap      = (mode != MODE_IDLE) && ($urandom_range(1, 0) == 1);
		case (mode)
			MODE_IDLE: begin
				nx_select = 1'b0;
				nx_en_1   = $urandom_range(1, 0) == 1;
				nx_en_2   = $urandom_range(1, 0) == 1;
				nx_type_1 = draw_type(1'b0);
				nx_type_2 = draw_type(1'b0);
			end
			MODE_BOTH: begin
				nx_select = 1'b1;
				nx_en_1   = 1'b1;
				nx_en_2   = 1'b1;
				nx_type_1 = draw_type(1'b1);
				nx_type_2 = draw_type(1'b1);
			end
			MODE_ONE: begin
				// Absent port is switched off but still sends words
				port_2_only = $urandom_range(1, 0) == 1;
				nx_select   = 1'b1;
				nx_en_1     = !port_2_only;
				nx_en_2     = port_2_only;
				nx_type_1   = draw_type(!port_2_only);
				nx_type_2   = draw_type(port_2_only);
			end
			default: begin
				nx_select = $urandom_range(4, 0) != 0;
				nx_en_1   = $urandom_range(3, 0) != 0;
				nx_en_2   = $urandom_range(3, 0) != 0;
				nx_type_1 = draw_type(1'b0);
				nx_type_2 = draw_type(1'b0);
				if ($urandom_range(2, 0) == 0) begin
					nx_buttons_1 = '0;
				end
				if ($urandom_range(2, 0) == 0) begin
					nx_buttons_2 = '0;
				end
			end
		endcase
	endtask

	// Drive one set, predict it, and check the set from two edges back
	task automatic run_cycle();
		logic        present_1;
		logic        present_2;
		logic [60:0] expected;
		@(posedge clk_sys);
		llapi_buttons_1 <= nx_buttons_1;
		llapi_buttons_2 <= nx_buttons_2;
		llapi_type_1    <= nx_type_1;
		llapi_type_2    <= nx_type_2;
		llapi_en_1      <= nx_en_1;
		llapi_en_2      <= nx_en_2;
		llapi_select    <= nx_select;
		{joy_usb_4, joy_usb_3, joy_usb_2, joy_usb_1, joy_usb_0} <= nx_usb;
		joy_swap        <= nx_swap;
		present_1 = pad_is_present(nx_en_1, nx_select, nx_type_1, pressed_1, nx_buttons_1);
		present_2 = pad_is_present(nx_en_2, nx_select, nx_type_2, pressed_2, nx_buttons_2);
		pressed_1 = pressed_1 || (nx_buttons_1 != '0);
		pressed_2 = pressed_2 || (nx_buttons_2 != '0);
		expected[59:0] = assign_slots(present_1, present_2, map_native(nx_buttons_1, nx_type_1),
			map_native(nx_buttons_2, nx_type_2), nx_usb, nx_swap);
		expected[60] = combo_held(nx_buttons_1) || combo_held(nx_buttons_2);
		@(negedge clk_sys);
		if (exp_q.size() == 2) begin
			compare_outputs(exp_q.pop_front());
		end
		exp_q.push_back(expected);
	endtask

	task automatic run_phase(input int mode, input int cycles);
		repeat (cycles) begin
			draw_stimulus(mode);
			run_cycle();
		end
	endtask

	// Both ports enabled with unidentified types and fixed button words
	task automatic run_unknown_type(input int cycles, input logic [31:0] word_1,
		input logic [31:0] word_2);
		repeat (cycles) begin
			draw_stimulus(MODE_BOTH);
			nx_type_1    = ($urandom_range(1, 0) == 1) ? 8'd255 : 8'd0;
			nx_type_2    = ($urandom_range(1, 0) == 1) ? 8'd255 : 8'd0;
			nx_buttons_1 = word_1;
			nx_buttons_2 = word_2;
			run_cycle();
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		reset     = 1'b0;
		pressed_1 = 1'b0;
		pressed_2 = 1'b0;
		drive_zero_inputs();
		void'($urandom(62));
		apply_reset();
		run_phase(MODE_IDLE, N_IDLE);
		run_phase(MODE_BOTH, N_BOTH);
		run_phase(MODE_ONE, N_ONE);

		// Sticky presence on port 1 and then on port 2
		apply_reset();
		run_unknown_type(STICKY_IDLE, 32'd0, 32'd0);
		run_unknown_type(1, draw_buttons() | 32'd1, 32'd0);
		run_unknown_type(STICKY_HOLD, 32'd0, 32'd0);
		run_unknown_type(1, 32'd0, draw_buttons() | 32'd1);
		run_unknown_type(STICKY_HOLD, 32'd0, 32'd0);
		apply_reset();
		run_unknown_type(STICKY_IDLE, 32'd0, 32'd0);

		for (int i = 0; i < N_RANDOM; i++) begin
			if (i % RESET_EVERY == 0) begin
				apply_reset();
			end
			draw_stimulus(MODE_RANDOM);
			run_cycle();
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
